// ==== design/eq_solver_pkg.sv ====
`default_nettype none

package eq_solver_pkg;

    localparam int coeff_w    = 8;
    localparam int rng_w      = 3;
    localparam int sel_w      = 3;
    localparam int num_coeffs = 6;
    localparam int num_sets   = 5;

    typedef logic [coeff_w-1:0] coeff_t;
    typedef logic [rng_w-1:0]   rng_t;
    typedef logic [sel_w-1:0]   reg_sel_t;

    // register file addresses, coefficients in row-major order
    localparam reg_sel_t sel_pivot = 3'd0;
    localparam reg_sel_t sel_r1    = 3'd1;
    localparam reg_sel_t sel_r2    = 3'd2;
    localparam reg_sel_t sel_r3    = 3'd3;
    localparam reg_sel_t sel_r4    = 3'd4;
    localparam reg_sel_t sel_r5    = 3'd5;
    localparam reg_sel_t sel_r6    = 3'd6;

    typedef enum logic {
        op_div,
        op_sub
    } grand_op_t;

    // elimination states sit at 16..31 so bits [3:2] give the phase and [1:0] the row
    typedef enum logic [4:0] {
        st_idle, st_seed_wait, st_load,
        st_get_x, st_x_release, st_get_y, st_y_release,
        st_compare, st_done, st_clear,
        st_p1_prep = 5'd16, st_p1_row_a, st_p1_row_b, st_p1_row_c,
        st_p2_prep, st_p2_row_a, st_p2_row_b, st_p2_row_c,
        st_p3_prep, st_p3_row_a, st_p3_row_b, st_p3_row_c,
        st_p4_prep, st_p4_row_a, st_p4_row_b, st_p4_row_c
    } solve_state_t;

    // a1, b1, c1, a2, b2, c2
    localparam coeff_t prob_table [num_sets][num_coeffs] = '{
        '{8'd2, 8'd2, 8'd10, 8'd1, 8'd4,  8'd8},
        '{8'd2, 8'd5, 8'd14, 8'd3, 8'd24, 8'd21},
        '{8'd2, 8'd2, 8'd12, 8'd2, 8'd6,  8'd24},
        '{8'd8, 8'd3, 8'd6,  8'd3, 8'd2,  8'd4},
        '{8'd7, 8'd2, 8'd2,  8'd1, 8'd9,  8'd9}
    };

endpackage

`default_nettype wire

// ==== design/problem_rng.sv ====
`timescale 1ns/1ps
`default_nettype none

module problem_rng (
    input  wire                  Clock,
    input  wire                  arst_n,
    input  wire                  seed_load,
    input  wire                  rng_step,
    input  eq_solver_pkg::rng_t  seed,
    output eq_solver_pkg::rng_t  prob_idx
);
    import eq_solver_pkg::*;

    rng_t step_value;
    logic mix;

    // bit 1 and bit 2 both take the xor of the old upper bits
    assign mix        = prob_idx[1] ^ prob_idx[2];
    assign step_value = {mix, mix, prob_idx[2]};

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            prob_idx <= '0;
        end else if (seed_load) begin
            // all-zero seed would lock the stepping rule
            prob_idx <= (seed == '0) ? rng_t'(1) : seed;
        end else if (rng_step) begin
            prob_idx <= step_value;
        end
    end

endmodule

`default_nettype wire

// ==== design/coeff_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module coeff_regfile (
    input  wire                      Clock,
    input  wire                      arst_n,
    input  wire                      clear,
    input  wire                      table_load,
    input  eq_solver_pkg::rng_t      prob_idx,
    input  wire                      pivot_load,
    input  eq_solver_pkg::reg_sel_t  pivot_sel,
    input  wire                      wr_en,
    input  eq_solver_pkg::reg_sel_t  wr_sel,
    input  eq_solver_pkg::coeff_t    wb_value,
    output eq_solver_pkg::coeff_t    pivot,
    output eq_solver_pkg::coeff_t    r1,
    output eq_solver_pkg::coeff_t    r2,
    output eq_solver_pkg::coeff_t    r3,
    output eq_solver_pkg::coeff_t    r4,
    output eq_solver_pkg::coeff_t    r5,
    output eq_solver_pkg::coeff_t    r6
);
    import eq_solver_pkg::*;

    // entry 0 is the pivot, 1..6 the coefficients
    coeff_t regs [0:num_coeffs];
    int unsigned set_idx;

    // index to problem set, pairs share a set below 6
    always_comb begin
        case (prob_idx)
            3'd0, 3'd1: set_idx = 0;
            3'd2, 3'd3: set_idx = 1;
            3'd4, 3'd5: set_idx = 2;
            3'd6:       set_idx = 3;
            default:    set_idx = 4;
        endcase
    end

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i <= num_coeffs; i++) begin
                regs[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i <= num_coeffs; i++) begin
                regs[i] <= '0;
            end
        end else if (table_load) begin
            for (int i = 0; i < num_coeffs; i++) begin
                regs[i+1] <= prob_table[set_idx][i];
            end
        end else if (pivot_load) begin
            if (pivot_sel <= reg_sel_t'(num_coeffs)) begin
                regs[sel_pivot] <= regs[pivot_sel];
            end
        end else if (wr_en) begin
            if (wr_sel <= reg_sel_t'(num_coeffs)) begin
                regs[wr_sel] <= wb_value;
            end
        end
    end

    assign pivot = regs[sel_pivot];
    assign r1    = regs[sel_r1];
    assign r2    = regs[sel_r2];
    assign r3    = regs[sel_r3];
    assign r4    = regs[sel_r4];
    assign r5    = regs[sel_r5];
    assign r6    = regs[sel_r6];

endmodule

`default_nettype wire

// ==== design/elim_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module elim_alu (
    input  eq_solver_pkg::coeff_t     pivot,
    input  eq_solver_pkg::coeff_t     r1,
    input  eq_solver_pkg::coeff_t     r2,
    input  eq_solver_pkg::coeff_t     r3,
    input  eq_solver_pkg::coeff_t     r4,
    input  eq_solver_pkg::coeff_t     r5,
    input  eq_solver_pkg::coeff_t     r6,
    input  eq_solver_pkg::reg_sel_t   src_a_sel,
    input  eq_solver_pkg::reg_sel_t   src_b_sel,
    input  wire                       prod_to_a,
    input  wire                       prod_to_b,
    input  eq_solver_pkg::grand_op_t  grand_op,
    output eq_solver_pkg::coeff_t     wb_value
);
    import eq_solver_pkg::*;

    coeff_t a_val;
    coeff_t b_val;
    coeff_t a_op;
    coeff_t b_op;
    coeff_t prod;
    logic [2*coeff_w-1:0] prod_full;

    function automatic coeff_t pick(input reg_sel_t sel);
        case (sel)
            sel_pivot: return pivot;
            sel_r1:    return r1;
            sel_r2:    return r2;
            sel_r3:    return r3;
            sel_r4:    return r4;
            sel_r5:    return r5;
            sel_r6:    return r6;
            default:   return '0;
        endcase
    endfunction

    always_comb begin
        a_val = pick(src_a_sel);
        b_val = pick(src_b_sel);
    end

    // product wraps to 8 bits
    assign prod_full = pivot * (prod_to_a ? a_val : b_val);
    assign prod      = prod_full[coeff_w-1:0];
    assign a_op      = prod_to_a ? prod : a_val;
    assign b_op      = prod_to_b ? prod : b_val;

    always_comb begin
        if (grand_op == op_div) begin
            wb_value = (a_op == '0) ? '0 : b_op / a_op;
        end else if (prod_to_a) begin
            wb_value = b_op - a_op;
        end else begin
            wb_value = a_op - b_op;
        end
    end

endmodule

`default_nettype wire

// ==== design/solve_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module solve_ctrl (
    input  wire                       Clock,
    input  wire                       arst_n,
    input  wire                       start,
    input  wire                       go,
    input  eq_solver_pkg::coeff_t     data_in,
    input  eq_solver_pkg::coeff_t     x_sol,
    input  eq_solver_pkg::coeff_t     y_sol,
    output logic                      seed_load,
    output logic                      rng_step,
    output logic                      table_load,
    output logic                      clear,
    output logic                      pivot_load,
    output eq_solver_pkg::reg_sel_t   pivot_sel,
    output logic                      wr_en,
    output eq_solver_pkg::reg_sel_t   wr_sel,
    output eq_solver_pkg::reg_sel_t   src_a_sel,
    output eq_solver_pkg::reg_sel_t   src_b_sel,
    output logic                      prod_to_a,
    output logic                      prod_to_b,
    output eq_solver_pkg::grand_op_t  grand_op,
    output logic                      correct
);
    import eq_solver_pkg::*;

    solve_state_t state;
    solve_state_t state_next;
    coeff_t x_ans;
    coeff_t y_ans;
    logic match_q;
    logic elim;
    logic [1:0] phase;
    logic [1:0] row;
    reg_sel_t row_lo;
    reg_sel_t row_hi;

    assign elim  = state[4];
    assign phase = state[3:2];
    assign row   = state[1:0];

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      if (start) state_next = st_seed_wait;
            st_seed_wait: state_next = st_load;
            st_load:      state_next = st_get_x;
            st_get_x:     if (go) state_next = st_x_release;
            st_x_release: if (!go) state_next = st_get_y;
            st_get_y:     if (go) state_next = st_y_release;
            st_y_release: if (!go) state_next = st_p1_prep;
            st_compare:   state_next = st_done;
            st_done: begin
                if (!match_q) begin
                    state_next = st_clear;
                end else if (start) begin
                    state_next = st_seed_wait;
                end
            end
            st_clear:     state_next = st_idle;
            st_p4_row_c:  state_next = st_compare;
            default: begin
                if (elim) begin
                    state_next = solve_state_t'(state + 5'd1);
                end else begin
                    state_next = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // answers and match flag
    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            x_ans   <= '0;
            y_ans   <= '0;
            match_q <= 1'b0;
        end else if (state == st_clear) begin
            x_ans   <= '0;
            y_ans   <= '0;
            match_q <= 1'b0;
        end else begin
            if (state == st_get_x && go) begin
                x_ans <= data_in;
            end
            if (state == st_get_y && go) begin
                y_ans <= data_in;
            end
            if (state == st_compare) begin
                match_q <= (x_ans == x_sol) && (y_ans == y_sol);
            end
        end
    end

    always_comb begin
        case (row)
            2'd1: begin
                row_lo = sel_r1;
                row_hi = sel_r4;
            end
            2'd2: begin
                row_lo = sel_r2;
                row_hi = sel_r5;
            end
            default: begin
                row_lo = sel_r3;
                row_hi = sel_r6;
            end
        endcase
    end

    always_comb begin
        pivot_load = 1'b0;
        pivot_sel  = sel_pivot;
        wr_en      = 1'b0;
        wr_sel     = sel_pivot;
        src_a_sel  = sel_pivot;
        src_b_sel  = sel_pivot;
        prod_to_a  = 1'b0;
        prod_to_b  = 1'b0;
        grand_op   = op_div;
        if (elim && row == 2'd0) begin
            pivot_load = 1'b1;
            case (phase)
                2'd0:    pivot_sel = sel_r1;
                2'd1:    pivot_sel = sel_r4;
                2'd2:    pivot_sel = sel_r5;
                default: pivot_sel = sel_r2;
            endcase
        end else if (elim) begin
            wr_en = 1'b1;
            case (phase)
                // row 1 divided by pivot
                2'd0: begin
                    src_b_sel = row_lo;
                    wr_sel    = row_lo;
                end
                // row 2 minus pivot times row 1
                2'd1: begin
                    src_a_sel = row_lo;
                    src_b_sel = row_hi;
                    prod_to_a = 1'b1;
                    grand_op  = op_sub;
                    wr_sel    = row_hi;
                end
                2'd2: begin
                    src_b_sel = row_hi;
                    wr_sel    = row_hi;
                end
                // back-substitution into row 1
                default: begin
                    src_a_sel = row_lo;
                    src_b_sel = row_hi;
                    prod_to_b = 1'b1;
                    grand_op  = op_sub;
                    wr_sel    = row_lo;
                end
            endcase
        end
    end

    assign seed_load  = start && (state == st_idle || (state == st_done && match_q));
    assign rng_step   = (state == st_seed_wait);
    assign table_load = (state == st_load);
    assign clear      = (state == st_clear);
    assign correct    = (state == st_done) && match_q;

endmodule

`default_nettype wire

// ==== design/eq_solver_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eq_solver_top (
    input  wire                    Clock,
    input  wire                    arst_n,
    input  wire                    start,
    input  wire                    go,
    input  eq_solver_pkg::rng_t    seed,
    input  eq_solver_pkg::coeff_t  data_in,
    output logic                   correct
);
    import eq_solver_pkg::*;

    logic seed_load;
    logic rng_step;
    logic table_load;
    logic clear;
    logic pivot_load;
    logic wr_en;
    logic prod_to_a;
    logic prod_to_b;
    reg_sel_t pivot_sel;
    reg_sel_t wr_sel;
    reg_sel_t src_a_sel;
    reg_sel_t src_b_sel;
    grand_op_t grand_op;
    rng_t prob_idx;
    coeff_t wb_value;
    coeff_t pivot;
    coeff_t r1;
    coeff_t r2;
    coeff_t r3;
    coeff_t r4;
    coeff_t r5;
    coeff_t r6;

    // solution lands in the last column, x = r3 and y = r6
    solve_ctrl solve_ctrl_inst (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .start      (start),
        .go         (go),
        .data_in    (data_in),
        .x_sol      (r3),
        .y_sol      (r6),
        .seed_load  (seed_load),
        .rng_step   (rng_step),
        .table_load (table_load),
        .clear      (clear),
        .pivot_load (pivot_load),
        .pivot_sel  (pivot_sel),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .src_a_sel  (src_a_sel),
        .src_b_sel  (src_b_sel),
        .prod_to_a  (prod_to_a),
        .prod_to_b  (prod_to_b),
        .grand_op   (grand_op),
        .correct    (correct)
    );

    problem_rng problem_rng_inst (
        .Clock     (Clock),
        .arst_n    (arst_n),
        .seed_load (seed_load),
        .rng_step  (rng_step),
        .seed      (seed),
        .prob_idx  (prob_idx)
    );

    coeff_regfile coeff_regfile_inst (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .clear      (clear),
        .table_load (table_load),
        .prob_idx   (prob_idx),
        .pivot_load (pivot_load),
        .pivot_sel  (pivot_sel),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wb_value   (wb_value),
        .pivot      (pivot),
        .r1         (r1),
        .r2         (r2),
        .r3         (r3),
        .r4         (r4),
        .r5         (r5),
        .r6         (r6)
    );

    elim_alu elim_alu_inst (
        .pivot     (pivot),
        .r1        (r1),
        .r2        (r2),
        .r3        (r3),
        .r4        (r4),
        .r5        (r5),
        .r6        (r6),
        .src_a_sel (src_a_sel),
        .src_b_sel (src_b_sel),
        .prod_to_a (prod_to_a),
        .prod_to_b (prod_to_b),
        .grand_op  (grand_op),
        .wb_value  (wb_value)
    );

endmodule

`default_nettype wire

// ==== test/eq_solver_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module eq_solver_sva (
    input  wire                          Clock,
    input  wire                          arst_n,
    input  wire                          go,
    input  wire                          correct,
    input  wire                          wr_en,
    input  wire                          pivot_load,
    input  eq_solver_pkg::solve_state_t  state
);
    import eq_solver_pkg::*;

    int unsigned fail_count = 0;

    // correct only comes out of a done state entered through compare
    correct_only_in_done: assert property (
        @(posedge Clock) disable iff (!arst_n)
        correct |-> (state == st_done) && ($past(state) inside {st_compare, st_done})
    ) else begin
        fail_count++;
        $error("correct high outside a done state reached through compare");
    end

    // each prep cycle is followed by its three row writes
    no_pivot_and_write: assert property (
        @(posedge Clock) disable iff (!arst_n)
        pivot_load |-> !wr_en ##1 (wr_en && !pivot_load) [*3] ##1 !wr_en
    ) else begin
        fail_count++;
        $error("pivot load not followed by exactly three separate row writes");
    end

    get_x_waits_for_go: assert property (
        @(posedge Clock) disable iff (!arst_n)
        (state == st_get_x && !go) |=> (state == st_get_x)
    ) else begin
        fail_count++;
        $error("left get_x while go was low");
    end

endmodule

bind solve_ctrl eq_solver_sva eq_solver_sva_inst (
    .Clock      (Clock),
    .arst_n     (arst_n),
    .go         (go),
    .correct    (correct),
    .wr_en      (wr_en),
    .pivot_load (pivot_load),
    .state      (state)
);

`default_nettype wire

// ==== test/eq_solver_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eq_solver_tb;
    import eq_solver_pkg::*;

    localparam int half_period = 10;
    localparam int drive_delay = 2;
    localparam int num_games   = 12;

    // a1, b1, c1, a2, b2, c2 for each problem set
    localparam coeff_t model_table [5][6] = '{
        '{8'd2, 8'd2, 8'd10, 8'd1, 8'd4,  8'd8},
        '{8'd2, 8'd5, 8'd14, 8'd3, 8'd24, 8'd21},
        '{8'd2, 8'd2, 8'd12, 8'd2, 8'd6,  8'd24},
        '{8'd8, 8'd3, 8'd6,  8'd3, 8'd2,  8'd4},
        '{8'd7, 8'd2, 8'd2,  8'd1, 8'd9,  8'd9}
    };

    logic   Clock;
    logic   arst_n;
    logic   start;
    logic   go;
    rng_t   seed;
    coeff_t data_in;
    logic   correct;
    integer rnd_seed;

    eq_solver_top eq_solver_top_inst (
        .Clock   (Clock),
        .arst_n  (arst_n),
        .start   (start),
        .go      (go),
        .seed    (seed),
        .data_in (data_in),
        .correct (correct)
    );

    always #half_period Clock = ~Clock;

    function automatic rng_t step_index(input rng_t idx);
        rng_t nxt;
        nxt[0] = idx[2];
        nxt[1] = idx[1] ^ idx[2];
        nxt[2] = nxt[1];
        return nxt;
    endfunction

    // indices below 6 come in pairs, 6 and 7 get their own set
    function automatic int set_for_index(input rng_t idx);
        if (idx < 3'd6) begin
            return int'(idx) / 2;
        end
        return int'(idx) - 3;
    endfunction

    function automatic void solve_model(input rng_t s, output coeff_t x, output coeff_t y);
        coeff_t m [1:6];
        coeff_t p;
        rng_t   idx;
        int     set;
        idx = (s == 3'd0) ? 3'd1 : s;
        idx = step_index(idx);
        set = set_for_index(idx);
        for (int i = 0; i < num_coeffs; i++) begin
            m[i+1] = model_table[set][i];
        end
        p = m[1];
        for (int i = 1; i <= 3; i++) begin
            m[i] = m[i] / p;
        end
        p = m[4];
        for (int i = 1; i <= 3; i++) begin
            m[i+3] = m[i+3] - coeff_t'(p * m[i]);
        end
        p = m[5];
        for (int i = 4; i <= 6; i++) begin
            m[i] = m[i] / p;
        end
        // back-substitution
        p = m[2];
        for (int i = 1; i <= 3; i++) begin
            m[i] = m[i] - coeff_t'(p * m[i+3]);
        end
        x = m[3];
        y = m[6];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h at %0t",
                                name, got, exp, $time));
        end
    endtask

    // bound checker failures end the run as well
    always @(negedge Clock) begin
        if (eq_solver_top_inst.solve_ctrl_inst.eq_solver_sva_inst.fail_count != 0) begin
            abort_run("a bound assertion on the control FSM failed");
        end
    end

    // inputs change and outputs are read a little after each rising edge
    task automatic next_cycle();
        @(posedge Clock);
        #drive_delay;
    endtask

    task automatic enter_value(input coeff_t value);
        int hold;
        hold = 1 + ($unsigned($random(rnd_seed)) % 8);
        data_in = value;
        go = 1'b1;
        repeat (hold) next_cycle();
        go = 1'b0;
        next_cycle();
    endtask

    task automatic play_game(input rng_t s, input coeff_t x_in, input coeff_t y_in);
        seed = s;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value("correct", correct, 1'b0);
        // get_x is reached three edges after start is seen
        repeat (2) next_cycle();
        enter_value(x_in);
        enter_value(y_in);
    endtask

    task automatic wait_correct(input int max_cycles);
        int n;
        n = 0;
        while (correct !== 1'b1) begin
            if (n == max_cycles) begin
                abort_run($sformatf("timeout: correct did not rise within %0d cycles",
                                    max_cycles));
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic expect_correct(input logic level, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_value("correct", correct, level);
            next_cycle();
        end
    endtask

    initial begin
        rng_t   s;
        coeff_t xe;
        coeff_t ye;
        rnd_seed = 21;
        Clock    = 1'b0;
        arst_n   = 1'b0;
        start    = 1'b0;
        go       = 1'b0;
        seed     = '0;
        data_in  = '0;
        repeat (8) @(posedge Clock);
        #drive_delay;
        arst_n = 1'b1;
        expect_correct(1'b0, 10);

        // first game uses the zero seed
        for (int g = 0; g < num_games; g++) begin
            s = (g == 0) ? 3'd0 : rng_t'($random(rnd_seed));
            solve_model(s, xe, ye);
            $display("game %0d seed %0d expects x=%0d y=%0d", g, s, xe, ye);
            if (g % 3 == 2) begin
                if (g % 2 == 0) begin
                    play_game(s, xe + 8'd1, ye);
                end else begin
                    play_game(s, xe, ye + 8'd3);
                end
                expect_correct(1'b0, 40);
            end
            play_game(s, xe, ye);
            wait_correct(40);
            expect_correct(1'b1, 20);
        end

        $display("All tests passed!");
        $finish;
    end

    initial begin
        #200_000;
        abort_run("timeout: simulation ran longer than the time limit");
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/eq_solver_pkg.sv
design/problem_rng.sv
design/coeff_regfile.sv
design/elim_alu.sv
design/solve_ctrl.sv
design/eq_solver_top.sv
test/eq_solver_sva.sv
test/eq_solver_tb.sv

// ==== Bender.yml ====
package:
  name: eq_solver

sources:
  - design/eq_solver_pkg.sv
  - design/problem_rng.sv
  - design/coeff_regfile.sv
  - design/elim_alu.sv
  - design/solve_ctrl.sv
  - design/eq_solver_top.sv
  - target: test
    files:
      - test/eq_solver_sva.sv
      - test/eq_solver_tb.sv
